//--- source/smu_ctrl_config.svh
////////////////////////////////////////
// smu control plane build constants
// frame geometry, register width, sync depth
////////////////////////////////////////

`ifndef SMU_CTRL_CONFIG_SVH
`define SMU_CTRL_CONFIG_SVH

// bits per spi frame, address then value
`define SMU_CTRL_FRAME_BITS 16

// width of the address field and of the value field
`define SMU_CTRL_FIELD_BITS 8

// control register width, set and clear halves of the value
`define SMU_CTRL_NIBBLE 4

// peripherals behind the second chip select
`define SMU_CTRL_PERIPHS 4

// flops in each pin synchronizer
`define SMU_CTRL_SYNC_STAGES 2

`endif

//--- source/spi_frame_pkg.sv
////////////////////////////////////////
// spi frame layout
// field types and bit positions of a frame
////////////////////////////////////////

`default_nettype none

`include "smu_ctrl_config.svh"

package spi_frame_pkg;

  // register address, upper byte of the frame
  typedef logic [`SMU_CTRL_FIELD_BITS-1:0] addr_t;

  // value, lower byte of the frame
  // low nibble sets bits, high nibble clears them
  typedef logic [`SMU_CTRL_FIELD_BITS-1:0] val_t;

  // counts up to a full frame, saturates past it
  typedef logic [$clog2(`SMU_CTRL_FRAME_BITS):0] bit_count_t;

  // count at which the address byte is in
  localparam bit_count_t ADDR_DONE_BIT = bit_count_t'(`SMU_CTRL_FIELD_BITS);

  // count of a complete, writable frame
  localparam bit_count_t FRAME_DONE_BIT = bit_count_t'(`SMU_CTRL_FRAME_BITS);

  // field positions inside the assembled frame
  localparam int unsigned ADDR_LSB = `SMU_CTRL_FIELD_BITS;
  localparam int unsigned VAL_LSB = 0;

  // nibble positions inside the value
  localparam int unsigned SET_LSB = 0;
  localparam int unsigned CLR_LSB = `SMU_CTRL_NIBBLE;

endpackage

`default_nettype wire

//--- source/smu_reg_pkg.sv
////////////////////////////////////////
// smu control register map
// addresses, register bank and presets
////////////////////////////////////////

`default_nettype none

`include "smu_ctrl_config.svh"

package smu_reg_pkg;

  // one control register
  typedef logic [`SMU_CTRL_NIBBLE-1:0] nibble_t;

  // register and command addresses
  typedef enum logic [`SMU_CTRL_FIELD_BITS-1:0] {
    POWERUP     = 8'd6,
    LED         = 8'd7,
    MUX         = 8'd8,
    DAC         = 8'd9,
    RAILS       = 8'd10,
    SOFT_RESET  = 8'd11,
    DAC_REF_MUX = 8'd12,
    ADC         = 8'd14,
    CLAMP1      = 8'd15,
    CLAMP2      = 8'd16,
    MON_RAILS   = 8'd19,
    RAILS_OE    = 8'd24
  } reg_addr_e;

  // all writable registers
  typedef struct packed {
    nibble_t led;
    nibble_t mux;
    nibble_t dac;
    nibble_t rails;
    nibble_t dac_ref_mux;
    nibble_t adc;
    nibble_t clamp1;
    nibble_t clamp2;
    nibble_t rails_oe;
  } reg_bank_t;

  // safe state, rails off
  // dg444 clamps are active low so all off means ones
  // rails_oe active low, held off until rails are checked
  localparam reg_bank_t SOFT_RESET_BANK = '{
    led: 4'h0, mux: 4'h0, dac: 4'h0, rails: 4'h0, dac_ref_mux: 4'h0,
    adc: 4'h0, clamp1: 4'hF, clamp2: 4'hF, rails_oe: 4'hF
  };

  // rails up, ref mux on, output enabled
  // mux and dac fields are placeholders, those registers keep their value
  localparam reg_bank_t POWERUP_BANK = '{
    led: 4'h0, mux: 4'h0, dac: 4'h0, rails: 4'h3, dac_ref_mux: 4'h3,
    adc: 4'h0, clamp1: 4'hF, clamp2: 4'hF, rails_oe: 4'h0
  };

endpackage

`default_nettype wire

//--- source/smu_ctrl_ifs.sv
////////////////////////////////////////
// stage interfaces
// sampler events, frame writes and reads
////////////////////////////////////////

`default_nettype none

// pin events in the clk domain
interface spi_event_if;
  logic sclk_rise;
  logic sclk_fall;
  logic frame_start;
  logic frame_end;
  logic mosi_s;

  modport sampler (output sclk_rise, sclk_fall, frame_start, frame_end, mosi_s);
  modport shifter (input sclk_rise, sclk_fall, frame_start, frame_end, mosi_s);
endinterface

// assembled frame towards the register file
interface spi_frame_if;
  import spi_frame_pkg::*;

  logic wr_valid;
  addr_t wr_addr;
  val_t wr_val;
  // held from the address byte to frame end
  addr_t rd_addr;
  val_t rd_data;

  modport shifter (output wr_valid, wr_addr, wr_val, rd_addr, input rd_data);
  modport regs (input wr_valid, wr_addr, wr_val, rd_addr, output rd_data);
endinterface

`default_nettype wire

//--- source/spi_sampler.sv
////////////////////////////////////////
// spi pin sampler
// syncs sclk, cs, mosi and emits edge strobes
////////////////////////////////////////

`default_nettype none

`include "smu_ctrl_config.svh"

module spi_sampler (
  input  logic clk,
  input  logic rst,
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  spi_event_if.sampler ev
);

  localparam int unsigned SYNC = `SMU_CTRL_SYNC_STAGES;

  // synchronizer plus one history stage per pin
  // [SYNC-1] is the current level, [SYNC] the previous one
  logic [SYNC:0] sclk_q;
  logic [SYNC:0] cs_q;
  logic [SYNC:0] mosi_q;

  ////////////////////////////////////////
  // synchronizers

  // idle levels: sclk low (mode 0), cs high
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sclk_q <= '0;
      cs_q <= '1;
    end
    else
    begin
      sclk_q <= {sclk_q[SYNC-1:0], sclk};
      cs_q <= {cs_q[SYNC-1:0], cs};
    end
  end

  // data only, follows the same depth
  always_ff @(posedge clk)
  begin
    mosi_q <= {mosi_q[SYNC-1:0], mosi};
  end

  ////////////////////////////////////////
  // edge strobes, one clk wide

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ev.sclk_rise <= 1'b0;
      ev.sclk_fall <= 1'b0;
      ev.frame_start <= 1'b0;
      ev.frame_end <= 1'b0;
    end
    else
    begin
      ev.sclk_rise <= sclk_q[SYNC-1] & ~sclk_q[SYNC];
      ev.sclk_fall <= ~sclk_q[SYNC-1] & sclk_q[SYNC];
      // cs active low
      ev.frame_start <= ~cs_q[SYNC-1] & cs_q[SYNC];
      ev.frame_end <= cs_q[SYNC-1] & ~cs_q[SYNC];
    end
  end

  // lines up with the strobes, mosi seen at the same clk as sclk
  assign ev.mosi_s = mosi_q[SYNC];

endmodule

`default_nettype wire

//--- source/spi_shifter.sv
////////////////////////////////////////
// spi frame shifter
// counts bits, builds the frame, shifts readback
////////////////////////////////////////

`default_nettype none

`include "smu_ctrl_config.svh"

module spi_shifter (
  input  logic clk,
  input  logic rst,
  spi_event_if.shifter ev,
  spi_frame_if.shifter fr,
  output logic dout
);

  import spi_frame_pkg::*;

  logic [`SMU_CTRL_FRAME_BITS-1:0] shift_in;
  bit_count_t bit_cnt;
  // our cs is low, sclk outside it belongs to the peripherals
  logic active;
  logic rise_in;
  logic addr_edge;
  logic rd_load;
  logic wr_valid_q;
  addr_t rd_addr_q;
  val_t out_sr;

  assign rise_in = ev.sclk_rise & active;
  // this rise completes the address byte
  assign addr_edge = rise_in && (bit_cnt == ADDR_DONE_BIT - 1'b1);

  ////////////////////////////////////////
  // frame control

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      active <= 1'b0;
      bit_cnt <= '0;
      rd_load <= 1'b0;
      wr_valid_q <= 1'b0;
      dout <= 1'b1;
    end
    else
    begin
      rd_load <= addr_edge;
      wr_valid_q <= 1'b0;
      if (ev.frame_start)
      begin
        active <= 1'b1;
        bit_cnt <= '0;
        dout <= 1'b1;
      end
      else if (ev.frame_end)
      begin
        active <= 1'b0;
        // short or long frames are dropped here
        wr_valid_q <= active && (bit_cnt == FRAME_DONE_BIT);
        dout <= 1'b1;
      end
      else
      begin
        // saturate so a very long frame cannot wrap back to 16
        if (rise_in && (bit_cnt != '1))
          bit_cnt <= bit_cnt + 1'b1;
        // ones during the address byte, then readback msb first
        if (ev.sclk_fall && active)
          dout <= (bit_cnt < ADDR_DONE_BIT) ? 1'b1 : out_sr[$high(out_sr)];
      end
    end
  end

  ////////////////////////////////////////
  // data path

  always_ff @(posedge clk)
  begin
    if (rise_in)
      shift_in <= {shift_in[`SMU_CTRL_FRAME_BITS-2:0], ev.mosi_s};
    // last address bit goes straight in with the shifted seven
    if (addr_edge)
      rd_addr_q <= {shift_in[`SMU_CTRL_FIELD_BITS-2:0], ev.mosi_s};
    if (rd_load)
      out_sr <= fr.rd_data;
    else if (ev.sclk_fall && active && (bit_cnt >= ADDR_DONE_BIT))
      out_sr <= {out_sr[$high(out_sr)-1:0], 1'b0};
  end

  assign fr.wr_valid = wr_valid_q;
  assign fr.wr_addr = shift_in[ADDR_LSB +: `SMU_CTRL_FIELD_BITS];
  assign fr.wr_val = shift_in[VAL_LSB +: `SMU_CTRL_FIELD_BITS];
  assign fr.rd_addr = rd_addr_q;

endmodule

`default_nettype wire

//--- source/reg_file.sv
////////////////////////////////////////
// smu control register file
// set/clear/toggle writes, presets, readback
////////////////////////////////////////

`default_nettype none

`include "smu_ctrl_config.svh"

module reg_file (
  input  logic clk,
  input  logic rst,
  spi_frame_if.regs fr,
  input  smu_reg_pkg::nibble_t mon_rails,
  output smu_reg_pkg::reg_bank_t bank
);

  import spi_frame_pkg::*;
  import smu_reg_pkg::*;

  reg_bank_t powerup_next;

  // set and clear both high on a bit toggles it
  // otherwise set first, then clear wins
  function automatic nibble_t update(input nibble_t cur, input val_t v);
    nibble_t set_bits;
    nibble_t clr_bits;
    nibble_t tog_bits;
    begin
      set_bits = v[SET_LSB +: `SMU_CTRL_NIBBLE];
      clr_bits = v[CLR_LSB +: `SMU_CTRL_NIBBLE];
      tog_bits = set_bits & clr_bits;
      if (|tog_bits)
        update = cur ^ tog_bits;
      else
        update = (cur | set_bits) & ~clr_bits;
    end
  endfunction

  // dac is set up before rails come on, mux may be mid transfer
  always_comb
  begin
    powerup_next = POWERUP_BANK;
    powerup_next.mux = bank.mux;
    powerup_next.dac = bank.dac;
  end

  ////////////////////////////////////////
  // writes

  always_ff @(posedge clk)
  begin
    if (rst)
      bank <= SOFT_RESET_BANK;
    else if (fr.wr_valid)
    begin
      case (fr.wr_addr)
        // commands
        SOFT_RESET:  bank <= SOFT_RESET_BANK;
        POWERUP:     bank <= powerup_next;
        // data registers
        LED:         bank.led <= update(bank.led, fr.wr_val);
        MUX:         bank.mux <= update(bank.mux, fr.wr_val);
        DAC:         bank.dac <= update(bank.dac, fr.wr_val);
        RAILS:       bank.rails <= update(bank.rails, fr.wr_val);
        DAC_REF_MUX: bank.dac_ref_mux <= update(bank.dac_ref_mux, fr.wr_val);
        ADC:         bank.adc <= update(bank.adc, fr.wr_val);
        CLAMP1:      bank.clamp1 <= update(bank.clamp1, fr.wr_val);
        CLAMP2:      bank.clamp2 <= update(bank.clamp2, fr.wr_val);
        RAILS_OE:    bank.rails_oe <= update(bank.rails_oe, fr.wr_val);
        // mon_rails is input only, unknown addresses ignored
        default:     bank <= bank;
      endcase
    end
  end

  ////////////////////////////////////////
  // readback, zero extended

  always_comb
  begin
    case (fr.rd_addr)
      LED:       fr.rd_data = val_t'(bank.led);
      MON_RAILS: fr.rd_data = val_t'(mon_rails);
      default:   fr.rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/periph_route.sv
////////////////////////////////////////
// peripheral spi routing
// cs2 selects peripherals chosen by mux
////////////////////////////////////////

`default_nettype none

`include "smu_ctrl_config.svh"

module periph_route (
  input  logic cs2,
  input  logic dout,
  input  smu_reg_pkg::nibble_t mux_sel,
  input  logic [`SMU_CTRL_PERIPHS-1:0] periph_miso,
  output logic [`SMU_CTRL_PERIPHS-1:0] periph_cs_n,
  output logic miso
);

  // cs2 high means not asserted
  // then all peripheral selects stay off and the fpga owns miso
  //
  // cs2 low: every peripheral with its mux bit set is selected
  // the host normally picks one, the or keeps miso defined if more are set

  logic [`SMU_CTRL_PERIPHS-1:0] sel_miso;

  // peripheral data masked by the mux register
  assign sel_miso = mux_sel & periph_miso;

  ////////////////////////////////////////
  // chip selects, active low

  always_comb
  begin
    if (cs2)
      periph_cs_n = '1;
    else
      periph_cs_n = ~mux_sel;
  end

  ////////////////////////////////////////
  // miso back to the host

  always_comb
  begin
    if (cs2)
      miso = dout;
    else
      miso = |sel_miso;
  end

endmodule

`default_nettype wire

//--- source/smu_ctrl_top.sv
////////////////////////////////////////
// smu spi control plane top level
// sampler, shifter, register file, routing
////////////////////////////////////////

`default_nettype none

`include "smu_ctrl_config.svh"

module smu_ctrl_top (
  input  logic clk,
  input  logic rst,
  // host spi
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  input  logic cs2,
  output logic miso,
  // peripheral spi
  input  logic [`SMU_CTRL_PERIPHS-1:0] periph_miso,
  output logic [`SMU_CTRL_PERIPHS-1:0] periph_cs_n,
  output logic periph_sclk,
  output logic periph_mosi,
  // board control
  input  logic [`SMU_CTRL_NIBBLE-1:0] mon_rails,
  output logic [`SMU_CTRL_NIBBLE-1:0] led,
  output logic [`SMU_CTRL_NIBBLE-1:0] dac_ctl,
  output logic [`SMU_CTRL_NIBBLE-1:0] rails,
  output logic [`SMU_CTRL_NIBBLE-1:0] rails_oe,
  output logic [`SMU_CTRL_NIBBLE-1:0] dac_ref_mux,
  output logic [`SMU_CTRL_NIBBLE-1:0] adc_ctl,
  output logic [`SMU_CTRL_NIBBLE-1:0] clamp1,
  output logic [`SMU_CTRL_NIBBLE-1:0] clamp2
);

  import smu_reg_pkg::*;

  reg_bank_t bank;
  logic dout;

  spi_event_if ev_if ();
  spi_frame_if fr_if ();

  ////////////////////////////////////////
  // fpga spi slave

  spi_sampler spi_sampler_inst (
    .clk  (clk),
    .rst  (rst),
    .sclk (sclk),
    .cs   (cs),
    .mosi (mosi),
    .ev   (ev_if.sampler)
  );

  spi_shifter spi_shifter_inst (
    .clk  (clk),
    .rst  (rst),
    .ev   (ev_if.shifter),
    .fr   (fr_if.shifter),
    .dout (dout)
  );

  reg_file reg_file_inst (
    .clk       (clk),
    .rst       (rst),
    .fr        (fr_if.regs),
    .mon_rails (mon_rails),
    .bank      (bank)
  );

  ////////////////////////////////////////
  // peripherals

  periph_route periph_route_inst (
    .cs2         (cs2),
    .dout        (dout),
    .mux_sel     (bank.mux),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

  // clock and data go to every peripheral, chip select decides
  assign periph_sclk = sclk;
  assign periph_mosi = mosi;

  // bank out to the pins
  assign led = bank.led;
  assign dac_ctl = bank.dac;
  assign rails = bank.rails;
  assign rails_oe = bank.rails_oe;
  assign dac_ref_mux = bank.dac_ref_mux;
  assign adc_ctl = bank.adc;
  assign clamp1 = bank.clamp1;
  assign clamp2 = bank.clamp2;

endmodule

`default_nettype wire

//--- bench/smu_ctrl_tb.sv
////////////////////////////////////////
// smu control plane testbench
// spi master, bank model, write/read/routing checks
////////////////////////////////////////

`default_nettype none

`include "smu_ctrl_config.svh"

module smu_ctrl_tb;

  import smu_reg_pkg::*;

  // sclk half period in clks for sclk at clk / 8
  localparam int HALF = 4;
  // cs rising to pins changing
  localparam int LATENCY = `SMU_CTRL_SYNC_STAGES + 3;

  logic clk;
  logic rst;
  logic sclk;
  logic cs;
  logic mosi;
  logic cs2;
  logic miso;
  logic [`SMU_CTRL_PERIPHS-1:0] periph_miso;
  logic [`SMU_CTRL_PERIPHS-1:0] periph_cs_n;
  logic periph_sclk;
  logic periph_mosi;
  logic [3:0] mon_rails;
  logic [3:0] led;
  logic [3:0] dac_ctl;
  logic [3:0] rails;
  logic [3:0] rails_oe;
  logic [3:0] dac_ref_mux;
  logic [3:0] adc_ctl;
  logic [3:0] clamp1;
  logic [3:0] clamp2;

  reg_bank_t model;
  integer seed;
  int errors;
  int checks;
  int tests_run;
  int err_mark;

  smu_ctrl_top smu_ctrl_top_inst (
    .clk (clk), .rst (rst), .sclk (sclk), .cs (cs), .mosi (mosi), .cs2 (cs2),
    .miso (miso), .periph_miso (periph_miso), .periph_cs_n (periph_cs_n),
    .periph_sclk (periph_sclk), .periph_mosi (periph_mosi), .mon_rails (mon_rails),
    .led (led), .dac_ctl (dac_ctl), .rails (rails), .rails_oe (rails_oe),
    .dac_ref_mux (dac_ref_mux), .adc_ctl (adc_ctl), .clamp1 (clamp1), .clamp2 (clamp2)
  );

  always #10 clk = ~clk;

  // peripherals stay deselected while cs2 is high
  assert property (@(posedge clk) disable iff (rst) cs2 |-> (periph_cs_n == '1))
  else
  begin
    errors++;
    $display("FAIL periph_cs_n with cs2 high: got 0x%0h, expected 0xf", periph_cs_n);
  end

  // sclk and mosi reach the peripherals unchanged
  assert property (@(posedge clk) periph_sclk === sclk)
  else
  begin
    errors++;
    $display("FAIL periph_sclk: got 0x%0h, expected 0x%0h", periph_sclk, sclk);
  end

  assert property (@(posedge clk) periph_mosi === mosi)
  else
  begin
    errors++;
    $display("FAIL periph_mosi: got 0x%0h, expected 0x%0h", periph_mosi, mosi);
  end

  ////////////////////////////////////////
  // reference model

  // toggle when set and clear overlap, else set then clear
  function automatic nibble_t next_nibble(input nibble_t cur, input logic [7:0] v);
    nibble_t both;
    begin
      both = v[3:0] & v[7:4];
      if (both != 4'h0)
        next_nibble = cur ^ both;
      else
        next_nibble = (cur | v[3:0]) & ~v[7:4];
    end
  endfunction

  task automatic load_reset_values();
    begin
      model = '0;
      model.clamp1 = 4'hF;
      model.clamp2 = 4'hF;
      model.rails_oe = 4'hF;
    end
  endtask

  task automatic model_write(input logic [7:0] addr, input logic [7:0] val);
    begin
      case (addr)
        SOFT_RESET: load_reset_values();
        // mux and dac untouched
        POWERUP:
        begin
          model.led = 4'h0;
          model.adc = 4'h0;
          model.rails_oe = 4'h0;
          model.rails = 4'h3;
          model.dac_ref_mux = 4'h3;
          model.clamp1 = 4'hF;
          model.clamp2 = 4'hF;
        end
        LED:         model.led = next_nibble(model.led, val);
        MUX:         model.mux = next_nibble(model.mux, val);
        DAC:         model.dac = next_nibble(model.dac, val);
        RAILS:       model.rails = next_nibble(model.rails, val);
        DAC_REF_MUX: model.dac_ref_mux = next_nibble(model.dac_ref_mux, val);
        ADC:         model.adc = next_nibble(model.adc, val);
        CLAMP1:      model.clamp1 = next_nibble(model.clamp1, val);
        CLAMP2:      model.clamp2 = next_nibble(model.clamp2, val);
        RAILS_OE:    model.rails_oe = next_nibble(model.rails_oe, val);
        default:     ;
      endcase
    end
  endtask

  ////////////////////////////////////////
  // helpers

  task automatic wait_clks(input int n);
    begin
      repeat (n) @(negedge clk);
    end
  endtask

  task automatic expect_hex(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    begin
      checks++;
      assert (got === exp)
      else
      begin
        errors++;
        $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
    end
  endtask

  // mux shows on the chip selects only while cs2 is low
  function automatic bit pins_match();
    pins_match = (led === model.led) && (dac_ctl === model.dac) &&
                 (rails === model.rails) && (rails_oe === model.rails_oe) &&
                 (dac_ref_mux === model.dac_ref_mux) && (adc_ctl === model.adc) &&
                 (clamp1 === model.clamp1) && (clamp2 === model.clamp2) &&
                 (periph_cs_n === nibble_t'(~model.mux));
  endfunction

  // mux is only visible through the chip selects
  task automatic check_bank();
    begin
      expect_hex("led", led, model.led);
      expect_hex("dac_ctl", dac_ctl, model.dac);
      expect_hex("rails", rails, model.rails);
      expect_hex("rails_oe", rails_oe, model.rails_oe);
      expect_hex("dac_ref_mux", dac_ref_mux, model.dac_ref_mux);
      expect_hex("adc_ctl", adc_ctl, model.adc);
      expect_hex("clamp1", clamp1, model.clamp1);
      expect_hex("clamp2", clamp2, model.clamp2);
      cs2 = 1'b0;
      wait_clks(1);
      expect_hex("periph_cs_n", periph_cs_n, nibble_t'(~model.mux));
      cs2 = 1'b1;
      wait_clks(1);
    end
  endtask

  // mode 0 master, msb first, miso taken just before each rise
  task automatic spi_frame(input logic [31:0] data, input int nbits,
                           output logic [31:0] rx);
    int i;
    begin
      rx = '0;
      cs = 1'b0;
      for (i = nbits - 1; i >= 0; i--)
      begin
        mosi = data[i];
        wait_clks(HALF);
        rx = {rx[30:0], miso};
        sclk = 1'b1;
        wait_clks(HALF);
        sclk = 1'b0;
      end
      wait_clks(HALF);
      cs = 1'b1;
    end
  endtask

  // starts at the cs rising edge
  // cs2 low so the mux register shows on the chip selects
  task automatic settle_check();
    int n;
    bit hit;
    begin
      hit = 1'b0;
      cs2 = 1'b0;
      for (n = 0; n < LATENCY && !hit; n++)
      begin
        @(negedge clk);
        hit = pins_match();
      end
      cs2 = 1'b1;
      if (!hit)
      begin
        errors++;
        $display("timeout: pins did not reach the model within %0d clks of cs rising",
                 LATENCY);
      end
      // full compare once the write slot has passed
      wait_clks(LATENCY - n + 1);
      check_bank();
    end
  endtask

  task automatic send_write(input logic [7:0] addr, input logic [7:0] val);
    logic [31:0] rx;
    begin
      spi_frame({16'h0, addr, val}, 16, rx);
      model_write(addr, val);
      settle_check();
    end
  endtask

  // value 0 on a read leaves the register as it is
  task automatic read_back(input logic [7:0] addr, input logic [7:0] exp);
    logic [31:0] rx;
    begin
      spi_frame({16'h0, addr, 8'h00}, 16, rx);
      model_write(addr, 8'h00);
      expect_hex("miso readback", rx[15:0], {8'hFF, exp});
      settle_check();
    end
  endtask

  task automatic report_test(input string name);
    begin
      tests_run++;
      if (errors == err_mark)
        $display("%-24s ok", name);
      else
        $display("%-24s %0d errors", name, errors - err_mark);
      err_mark = errors;
    end
  endtask

  ////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [31:0] rx;
    logic [7:0] data_addrs [9];
    logic [3:0] pm;
    int i;
    int j;

    data_addrs = '{LED, MUX, DAC, RAILS, DAC_REF_MUX, ADC, CLAMP1, CLAMP2, RAILS_OE};
    seed = 32'h9c1a_2c9e;
    errors = 0;
    checks = 0;
    tests_run = 0;
    err_mark = 0;
    clk = 1'b0;
    rst = 1'b1;
    sclk = 1'b0;
    cs = 1'b1;
    mosi = 1'b0;
    cs2 = 1'b1;
    periph_miso = '0;
    mon_rails = 4'h0;
    load_reset_values();
    wait_clks(4);
    rst = 1'b0;
    wait_clks(2);

    // 1. reset state
    check_bank();
    expect_hex("periph_cs_n", periph_cs_n, 4'hF);
    expect_hex("miso", miso, 1'b1);
    report_test("reset");

    // 2. set/clear/toggle on every data register
    send_write(LED, 8'h55);
    for (j = 0; j < 4; j++)
      for (i = 0; i < 9; i++)
        send_write(data_addrs[i], 8'($random(seed)));
    report_test("random writes");

    // 3. presets
    send_write(MUX, 8'h0A);
    send_write(DAC, 8'h06);
    // every preset field away from its powerup value
    send_write(LED, 8'h0F);
    send_write(ADC, 8'h0F);
    send_write(RAILS_OE, 8'h0F);
    send_write(RAILS, 8'h3C);
    send_write(DAC_REF_MUX, 8'h3C);
    send_write(CLAMP1, 8'hF0);
    send_write(CLAMP2, 8'hF0);
    send_write(POWERUP, 8'($random(seed)));
    // and away from the reset values
    send_write(LED, 8'h0F);
    send_write(ADC, 8'h0F);
    send_write(CLAMP1, 8'hF0);
    send_write(CLAMP2, 8'hF0);
    send_write(SOFT_RESET, 8'($random(seed)));
    report_test("presets");

    // 4. short and long frames are dropped
    send_write(LED, 8'hF0);
    spi_frame({16'h0, 8'(LED), 8'h0F}, 15, rx);
    settle_check();
    spi_frame({15'h0, 1'b1, 8'(LED), 8'h0F}, 17, rx);
    settle_check();
    report_test("bad bit count");

    // 5. readback
    send_write(LED, 8'h09);
    read_back(LED, {4'h0, model.led});
    mon_rails = 4'($random(seed)) | 4'h2;
    read_back(MON_RAILS, {4'h0, mon_rails});
    read_back(8'h30, 8'h00);
    report_test("readback");

    // 6. peripheral routing
    send_write(MUX, 8'h0F & (8'($random(seed)) | 8'h01));
    cs2 = 1'b0;
    for (i = 0; i < 8; i++)
    begin
      pm = 4'($random(seed));
      periph_miso = pm;
      wait_clks(1);
      expect_hex("periph_cs_n", periph_cs_n, nibble_t'(~model.mux));
      expect_hex("miso", miso, |(model.mux & pm));
    end
    cs2 = 1'b1;
    wait_clks(1);
    expect_hex("periph_cs_n", periph_cs_n, 4'hF);
    expect_hex("miso", miso, 1'b1);
    report_test("routing");

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- smu_ctrl.f
+incdir+source
source/spi_frame_pkg.sv
source/smu_reg_pkg.sv
source/smu_ctrl_ifs.sv
source/spi_sampler.sv
source/spi_shifter.sv
source/reg_file.sv
source/periph_route.sv
source/smu_ctrl_top.sv
bench/smu_ctrl_tb.sv

//--- Bender.yml
package:
  name: smu_ctrl

export_include_dirs:
  - source

sources:
  - files:
      - source/spi_frame_pkg.sv
      - source/smu_reg_pkg.sv
      - source/smu_ctrl_ifs.sv
      - source/spi_sampler.sv
      - source/spi_shifter.sv
      - source/reg_file.sv
      - source/periph_route.sv
      - source/smu_ctrl_top.sv
  - target: test
    files:
      - bench/smu_ctrl_tb.sv
